// ==== Makefile ====
# Verilator build and run of the gain and interpolation testbench
SIM      = verilator
TOP      = interpTb
FILELIST = sources.f
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/interpTb.sv ====
// Testbench for the gain and interpolation block, built with four sources.
// Register settings only change while the sample path is empty, so the reference
// model applies one set of settings to a whole stream.
// Samples are driven every other cycle, as the block requires.

`timescale 1ns/1ps

module interpTb;
    import interpPkg::*;

    localparam int NumSources     = 4;
    localparam int ClkPeriod      = 10;
    localparam int NumDriven      = 4 * 24 + 6 * 16 + 4 * 12 + 4 * 16;
    localparam int WatchdogCycles = NumDriven * 4 + 2000;
    localparam longint MaxSample  = 131071;
    localparam longint MinSample  = -131072;

    logic                                busClk;
    logic                                arstN;
    logic                                cs;
    logic                                wr0;
    logic                                wr1;
    logic                                wr2;
    logic                                wr3;
    logic [12:0]                         addr;
    logic [31:0]                         dataIn;
    logic [31:0]                         dataOut;
    logic [NumSources*SampleWidth-1:0]   sourceData;
    logic                                sampleValid;
    logic signed [SampleWidth-1:0]       sampleOut;
    logic                                outValid;

    logic signed [SampleWidth-1:0] expQ[$];  // Expected outputs in order
    int     valueErrors = 0;
    int     protoErrors = 0;
    int     expCount    = 0;
    int     actCount    = 0;
    string  testName    = "reset";
    logic [31:0] lfsrState = 32'd4;

    // Settings as the reference model sees them
    bit     mBypass;
    bit     mTest;
    bit     mInvert;
    bit     mBypassEq;
    int     mSrc;
    longint mMant;
    int     mExp;
    longint mTestVal;
    longint h1;     // Equalizer history, newest first
    longint h2;
    longint yPrev;  // Last filtered value, for the midpoint

    interpTop #(
        .NumSources(NumSources)
    ) dut_i (
        .busClk(busClk), .arstN(arstN), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .dataIn(dataIn), .dataOut(dataOut),
        .sourceData(sourceData), .sampleValid(sampleValid),
        .sampleOut(sampleOut), .outValid(outValid)
    );

    always #(ClkPeriod / 2) busClk = ~busClk;

    // Each output must stem from a sample five cycles back, or six for a second half
    latencyCheck: assert property (@(posedge busClk) disable iff (!arstN)
        outValid |-> ($past(sampleValid, 5) || $past(sampleValid, 6)))
    else begin
        protoErrors++;
        $display("Output at %0t in test %s has no sample five or six cycles earlier",
                 $time, testName);
    end

    always @(negedge busClk) begin : outputCheck
        logic signed [SampleWidth-1:0] expVal;
        if (arstN && outValid) begin
            actCount++;
            if (expQ.size() == 0) begin
                protoErrors++;
                $display("Stray output %0d in test %s while nothing was expected",
                         sampleOut, testName);
            end else begin
                expVal = expQ.pop_front();
                outValue: assert (sampleOut == expVal) else begin
                    valueErrors++;
                    $display("** Error in %s: expected %0d, actual %0d",
                             testName, expVal, sampleOut);
                end
            end
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic longint randBits(input int n);
        longint v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | longint'(lfsrState[0]);
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hD0000001) : (lfsrState >> 1);
        end
        return v;
    endfunction

    task automatic pushValue(input longint v);
        expQ.push_back(v[SampleWidth-1:0]);
        expCount++;
    endtask

    // Applies gain, 1-2-1 filter and upsampling to one selected sample
    task automatic pushExpected(input longint sel);
        longint prod;
        longint g;
        longint y;
        prod = (sel * mMant) >>> mExp;
        if (mInvert) begin
            prod = -prod;  // Negated before it is clipped
        end
        g = (prod > MaxSample) ? MaxSample : ((prod < MinSample) ? MinSample : prod);
        y = mBypassEq ? g : ((g + 2 * h1 + h2) >>> 2);
        h2 = h1;
        h1 = g;
        if (!mBypass) begin
            pushValue((yPrev + y) >>> 1);
        end
        pushValue(y);
        yPrev = y;
    endtask

    task automatic busWrite(input logic [12:0] a, input logic [31:0] d,
                            input logic [3:0] strobes);
        @(posedge busClk);
        #1;
        cs = 1'b1;
        {wr3, wr2, wr1, wr0} = strobes;
        addr = a;
        dataIn = d;
        @(posedge busClk);  // The write lands on this edge
        #1;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic checkReg(input logic [12:0] a, input logic [31:0] expVal);
        logic [31:0] got;
        @(posedge busClk);
        #1;
        cs = 1'b1;
        addr = a;
        @(negedge busClk);
        got = dataOut;
        @(posedge busClk);
        #1;
        cs = 1'b0;
        regValue: assert (got == expVal) else begin
            valueErrors++;
            $display("** Error in %s: register %h expected %h, actual %h",
                     testName, a, expVal, got);
        end
    endtask

    task automatic setConfig(input bit byp, input bit tst, input bit inv, input bit bypEq,
                             input logic [3:0] src, input logic [17:0] mant,
                             input logic [4:0] expo, input logic signed [17:0] tval);
        busWrite(RegControl, {28'h0, bypEq, inv, tst, byp}, 4'b0001);
        busWrite(RegSource, {12'h0, src, 16'h0}, 4'b0100);
        busWrite(RegMantissa, {14'h0, mant}, 4'b0111);
        busWrite(RegExponent, {27'h0, expo}, 4'b0001);
        busWrite(RegTest, {14'h0, tval}, 4'b0111);
        mBypass   = byp;
        mTest     = tst;
        mInvert   = inv;
        mBypassEq = bypEq;
        mSrc      = int'(src);
        mMant     = longint'(mant);
        mExp      = int'(expo);
        mTestVal  = longint'(tval);
    endtask

    task automatic driveSample();
        logic [NumSources*SampleWidth-1:0] samples;
        longint r;
        longint sel;
        for (int i = 0; i < NumSources; i++) begin
            r = randBits(SampleWidth);
            samples[i*SampleWidth +: SampleWidth] = r[SampleWidth-1:0];
        end
        sel = 0;  // Out of range index gives zero
        if (mTest) begin
            sel = mTestVal;
        end else if (mSrc < NumSources) begin
            sel = longint'($signed(samples[mSrc*SampleWidth +: SampleWidth]));
        end
        @(posedge busClk);
        #1;
        sourceData  = samples;
        sampleValid = 1'b1;
        pushExpected(sel);
        @(posedge busClk);
        #1;
        sampleValid = 1'b0;
        r = randBits(SampleWidth);
        sourceData = {NumSources{r[SampleWidth-1:0]}};  // Junk between strobes
    endtask

    // Waits until every expected output has come out, then a few idle cycles
    task automatic runStream(input int count);
        int waited;
        repeat (count) driveSample();
        waited = 0;
        while (expQ.size() != 0 && waited < 40) begin
            @(posedge busClk);
            waited++;
        end
        if (expQ.size() != 0) begin
            protoErrors++;
            $display("Test %s: %0d expected outputs never appeared", testName, expQ.size());
        end
        repeat (4) @(posedge busClk);
    endtask

    initial begin : watchdog
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog ran out after %0d cycles during test %s", WatchdogCycles, testName);
        $display("Simulation failed");
        $finish;
    end

    initial begin : mainSeq
        longint rm;
        longint re;
        longint ri;
        busClk = 1'b0;
        arstN = 1'b0;
        cs = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr = 13'h0;
        dataIn = 32'h0;
        sourceData = '0;
        sampleValid = 1'b0;
        {mBypass, mTest, mInvert, mBypassEq} = 4'b0000;
        mSrc = 0;
        mMant = 1;
        mExp = 0;
        mTestVal = 0;
        h1 = 0;
        h2 = 0;
        yPrev = 0;
        repeat (5) @(posedge busClk);
        #1;
        arstN = 1'b1;

        testName = "registers";
        checkReg(RegControl, 32'h0);
        checkReg(RegSource, 32'h0);
        checkReg(RegMantissa, 32'h1);
        checkReg(RegExponent, 32'h0);
        checkReg(RegTest, 32'h0);
        checkReg(13'h014, 32'h0);
        checkReg(13'h1FFC, 32'h0);
        busWrite(RegMantissa, 32'h0003FFFF, 4'b1111);
        checkReg(RegMantissa, 32'h0003FFFF);
        busWrite(RegMantissa, 32'h0, 4'b0010);  // Only bits 15..8 clear
        checkReg(RegMantissa, 32'h000300FF);
        busWrite(RegMantissa, 32'h0000005A, 4'b0001);
        checkReg(RegMantissa, 32'h0003005A);
        busWrite(RegMantissa, 32'h00010000, 4'b0100);
        checkReg(RegMantissa, 32'h0001005A);
        busWrite(RegMantissa, 32'hFFFFFFFF, 4'b1000);
        checkReg(RegMantissa, 32'h0001005A);
        busWrite(RegControl, 32'hFFFFFFFF, 4'b0001);
        busWrite(RegControl, 32'h0, 4'b0100);
        busWrite(RegSource, 32'hFFFFFFFF, 4'b0010);
        busWrite(RegSource, 32'h000A0000, 4'b0100);
        checkReg(RegControl, 32'h000A000F);
        checkReg(RegSource, 32'h000A000F);
        busWrite(RegExponent, 32'hFFFFFFFF, 4'b0001);
        checkReg(RegExponent, 32'h0000001F);
        busWrite(RegTest, 32'hFFFEABCD, 4'b0111);
        checkReg(RegTest, 32'h0002ABCD);

        testName = "sources";
        for (int s = 0; s < NumSources; s++) begin
            setConfig(1'b0, 1'b0, 1'b0, 1'b0, 4'(s), 18'd1, 5'd0, 18'sd0);
            runStream(24);
        end

        testName = "gain";
        for (int k = 0; k < 4; k++) begin
            rm = randBits(SampleWidth);
            re = randBits(4);
            ri = randBits(1);
            setConfig(1'b0, 1'b0, ri[0], 1'b0, 4'd2, rm[17:0], re[4:0], 18'sd0);
            runStream(16);
        end
        setConfig(1'b0, 1'b0, 1'b0, 1'b0, 4'd1, 18'h3FFFF, 5'd0, 18'sd0);  // Clips both ways
        runStream(16);
        setConfig(1'b0, 1'b0, 1'b1, 1'b0, 4'd3, 18'h3FFFF, 5'd0, 18'sd0);
        runStream(16);

        testName = "test value";
        rm = randBits(SampleWidth);
        setConfig(1'b0, 1'b1, 1'b0, 1'b0, 4'd0, 18'd1, 5'd0, rm[17:0]);
        runStream(12);
        setConfig(1'b0, 1'b1, 1'b1, 1'b0, 4'd0, 18'd1, 5'd0, 18'sh20000);
        runStream(12);
        setConfig(1'b0, 1'b0, 1'b0, 1'b0, 4'd4, 18'd1, 5'd0, 18'sd0);
        runStream(12);
        setConfig(1'b0, 1'b0, 1'b0, 1'b0, 4'd15, 18'd1, 5'd0, 18'sd0);
        runStream(12);

        testName = "bypass";
        setConfig(1'b0, 1'b0, 1'b0, 1'b1, 4'd0, 18'd1, 5'd0, 18'sd0);
        runStream(16);
        setConfig(1'b1, 1'b0, 1'b0, 1'b0, 4'd1, 18'd1, 5'd0, 18'sd0);
        runStream(16);
        setConfig(1'b0, 1'b0, 1'b0, 1'b0, 4'd2, 18'd1, 5'd0, 18'sd0);
        runStream(16);
        setConfig(1'b1, 1'b0, 1'b0, 1'b1, 4'd3, 18'd1, 5'd0, 18'sd0);
        runStream(16);

        if (expQ.size() != 0) begin
            protoErrors++;
            $display("%0d expected outputs are left over at the end", expQ.size());
        end
        if (expCount != actCount) begin
            protoErrors++;
            $display("Expected %0d outputs in total but the DUT gave %0d", expCount, actCount);
        end
        $display("Errors: %0d wrong values, %0d other failures", valueErrors, protoErrors);
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/interpPkg.sv
verilog/interpRegs.sv
verilog/interpSourceSel.sv
verilog/interpGain.sv
verilog/interpEqualizer.sv
verilog/interpUpsampler.sv
verilog/interpTop.sv
bench/interpTb.sv

// ==== verilog/interpEqualizer.sv ====
// Fixed 1-2-1 smoothing filter, one cycle from gainValid to eqValid.
// The history only advances on valid samples and keeps advancing while bypassed,
// so leaving bypass does not replay stale values.

`timescale 1ns/1ps

module interpEqualizer (
    input  logic                                     busClk,
    input  logic                                     arstN,
    input  logic signed [interpPkg::SampleWidth-1:0] gainData,
    input  logic                                     gainValid,
    input  logic                                     bypassEQ,
    output logic signed [interpPkg::SampleWidth-1:0] eqData,
    output logic                                     eqValid
);
    import interpPkg::*;

    logic signed [SampleWidth-1:0] hist1;  // Previous valid sample
    logic signed [SampleWidth-1:0] hist2;  // The one before that
    logic signed [SampleWidth+1:0] sum;

    // Two guard bits hold x + 2y + z without overflow
    assign sum = gainData + (hist1 <<< 1) + hist2;

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            hist1   <= '0;
            hist2   <= '0;
            eqValid <= 1'b0;
        end else begin
            eqValid <= gainValid;
            if (gainValid) begin
                hist2 <= hist1;
                hist1 <= gainData;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (gainValid) begin
            // Dropping the two low bits is the arithmetic shift by two
            eqData <= bypassEQ ? gainData : sum[SampleWidth+1:2];
        end
    end

endmodule

// ==== verilog/interpGain.sv ====
// Gain stage, two cycles from selValid to gainValid.
// The gain is mantissa * 2^-exponent with an unsigned 18-bit mantissa.
// Negation comes before saturation, so an inverted negative full scale sample
// ends up at the positive maximum.

`timescale 1ns/1ps

module interpGain (
    input  logic                                     busClk,
    input  logic                                     arstN,
    input  logic signed [interpPkg::SampleWidth-1:0] selData,
    input  logic                                     selValid,
    input  logic [17:0]                              mantissa,
    input  logic [4:0]                               exponent,
    input  logic                                     invert,
    output logic signed [interpPkg::SampleWidth-1:0] gainData,
    output logic                                     gainValid
);
    import interpPkg::*;

    // Full product plus one bit of room so the negation cannot overflow
    localparam int ProdWidth = SampleWidth + 19;
    localparam int TopBits   = ProdWidth - SampleWidth + 1;

    logic signed [ProdWidth-1:0]   prodReg;
    logic                          prodValid;
    logic signed [ProdWidth-1:0]   shifted;
    logic signed [ProdWidth-1:0]   scaled;
    logic signed [SampleWidth-1:0] satData;

    always_comb begin
        shifted = prodReg >>> exponent;
        scaled  = invert ? -shifted : shifted;
        // In range when all bits above the sample sign agree with it
        if (scaled[ProdWidth-1:SampleWidth-1] == {TopBits{scaled[ProdWidth-1]}}) begin
            satData = scaled[SampleWidth-1:0];
        end else if (scaled[ProdWidth-1]) begin
            satData = {1'b1, {(SampleWidth-1){1'b0}}};
        end else begin
            satData = {1'b0, {(SampleWidth-1){1'b1}}};
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            prodValid <= 1'b0;
            gainValid <= 1'b0;
        end else begin
            prodValid <= selValid;
            gainValid <= prodValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (selValid) begin
            prodReg <= selData * $signed({1'b0, mantissa});  // Mantissa kept positive
        end
        if (prodValid) begin
            gainData <= satData;
        end
    end

endmodule

// ==== verilog/interpPkg.sv ====
// Shared definitions of the gain and interpolation block.
// Samples are signed two's complement of SampleWidth bits.
// Register addresses are byte addresses on the 32-bit processor bus. Only the low 13
// address bits are decoded.

package interpPkg;

    // Width of every sample on the receive path
    parameter int SampleWidth = 18;

    // Register map of the bus bank
    typedef enum logic [12:0] {
        RegControl  = 13'h000,  // bypass, test, invert, bypassEQ in bits 3..0
        RegSource   = 13'h004,  // Source index in bits 19..16
        RegMantissa = 13'h008,  // Unsigned 18-bit gain mantissa
        RegExponent = 13'h00C,  // Right shift applied after the multiply
        RegTest     = 13'h010   // Signed test sample
    } RegAddr;

    // After reset the gain is x1 with no shift, so samples pass unchanged
    parameter logic [17:0] MantissaReset = 18'd1;
    parameter logic [4:0]  ExponentReset = 5'd0;

endpackage

// ==== verilog/interpRegs.sv ====
// Control registers of the gain and interpolation block.
// A write takes effect at the rising busClk edge where cs and a byte strobe are high.
// Each strobe only touches its own byte lane. Lane 3 holds no field, so wr3 is ignored.
// dataOut is combinational and meaningful only while cs is high. It reads zero otherwise.

`timescale 1ns/1ps

module interpRegs (
    input  logic                                  busClk,
    input  logic                                  arstN,
    input  logic                                  cs,
    input  logic                                  wr0,
    input  logic                                  wr1,
    input  logic                                  wr2,
    input  logic                                  wr3,
    input  logic [12:0]                           addr,
    input  logic [31:0]                           dataIn,
    output logic [31:0]                           dataOut,
    output logic                                  bypass,
    output logic                                  test,
    output logic                                  invert,
    output logic                                  bypassEQ,
    output logic [3:0]                            source,
    output logic signed [interpPkg::SampleWidth-1:0] testValue,
    output logic [4:0]                            exponent,
    output logic [17:0]                           mantissa
);
    import interpPkg::*;

    logic [31:0] controlWord;

    // Control and source share one read-back word
    assign controlWord = {12'h0, source, 12'h0, bypassEQ, invert, test, bypass};

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            bypass    <= 1'b0;
            test      <= 1'b0;
            invert    <= 1'b0;
            bypassEQ  <= 1'b0;
            source    <= 4'h0;
            testValue <= '0;
            exponent  <= ExponentReset;
            mantissa  <= MantissaReset;
        end else begin
            // Byte lane 0
            if (cs && wr0) begin
                case (addr)
                    RegControl: begin
                        bypass   <= dataIn[0];
                        test     <= dataIn[1];
                        invert   <= dataIn[2];
                        bypassEQ <= dataIn[3];
                    end
                    RegMantissa: mantissa[7:0]  <= dataIn[7:0];
                    RegExponent: exponent       <= dataIn[4:0];
                    RegTest:     testValue[7:0] <= dataIn[7:0];
                    default: ;
                endcase
            end
            if (cs && wr1) begin  // Byte lane 1
                case (addr)
                    RegMantissa: mantissa[15:8]  <= dataIn[15:8];
                    RegTest:     testValue[15:8] <= dataIn[15:8];
                    default: ;
                endcase
            end
            // Byte lane 2 carries the source index and the top bits of 18-bit fields
            if (cs && wr2) begin
                case (addr)
                    RegSource:   source           <= dataIn[19:16];
                    RegMantissa: mantissa[17:16]  <= dataIn[17:16];
                    RegTest:     testValue[17:16] <= dataIn[17:16];
                    default: ;
                endcase
            end
        end
    end

    // Read mux, zero filled
    always_comb begin
        dataOut = 32'h0;
        if (cs) begin
            case (addr)
                RegControl:  dataOut = controlWord;
                RegSource:   dataOut = controlWord;
                RegMantissa: dataOut = {14'h0, mantissa};
                RegExponent: dataOut = {27'h0, exponent};
                RegTest:     dataOut = {14'h0, testValue};  // Not sign extended
                default:     dataOut = 32'h0;
            endcase
        end
    end

endmodule

// ==== verilog/interpSourceSel.sv ====
// First stage of the sample path. One cycle from sampleValid to selValid.
// Source i sits in sourceData[i*SampleWidth +: SampleWidth].
// A source index at or above NumSources gives a zero sample.

`timescale 1ns/1ps

module interpSourceSel #(
    parameter int NumSources = 4
) (
    input  logic                                             busClk,
    input  logic                                             arstN,
    input  logic [NumSources*interpPkg::SampleWidth-1:0]     sourceData,
    input  logic                                             sampleValid,
    input  logic [3:0]                                       source,
    input  logic                                             test,
    input  logic signed [interpPkg::SampleWidth-1:0]         testValue,
    output logic signed [interpPkg::SampleWidth-1:0]         selData,
    output logic                                             selValid
);
    import interpPkg::*;

    logic signed [SampleWidth-1:0] picked;

    always_comb begin
        picked = '0;
        for (int i = 0; i < NumSources; i++) begin
            if (int'(source) == i) begin
                picked = sourceData[i*SampleWidth +: SampleWidth];
            end
        end
        if (test) begin
            picked = testValue;  // Test value wins over any source
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            selValid <= 1'b0;
        end else begin
            selValid <= sampleValid;
        end
    end

    always_ff @(posedge busClk) begin
        if (sampleValid) begin
            selData <= picked;
        end
    end

endmodule

// ==== verilog/interpTop.sv ====
// Gain and interpolation block of the receive sample path.
// sampleValid may be high at most every other cycle and there is no back-pressure.
// Latency is 5 cycles to the first output. With interpolation on the sample itself
// follows one cycle after its midpoint.
// NumSources may range from 1 to 16.

`timescale 1ns/1ps

module interpTop #(
    parameter int NumSources = 4
) (
    input  logic                                         busClk,
    input  logic                                         arstN,
    input  logic                                         cs,
    input  logic                                         wr0,
    input  logic                                         wr1,
    input  logic                                         wr2,
    input  logic                                         wr3,
    input  logic [12:0]                                  addr,
    input  logic [31:0]                                  dataIn,
    output logic [31:0]                                  dataOut,
    input  logic [NumSources*interpPkg::SampleWidth-1:0] sourceData,
    input  logic                                         sampleValid,
    output logic signed [interpPkg::SampleWidth-1:0]     sampleOut,
    output logic                                         outValid
);
    import interpPkg::*;

    logic                          bypass;
    logic                          test;
    logic                          invert;
    logic                          bypassEQ;
    logic [3:0]                    source;
    logic signed [SampleWidth-1:0] testValue;
    logic [4:0]                    exponent;
    logic [17:0]                   mantissa;

    logic signed [SampleWidth-1:0] selData;
    logic                          selValid;
    logic signed [SampleWidth-1:0] gainData;
    logic                          gainValid;
    logic signed [SampleWidth-1:0] eqData;
    logic                          eqValid;

    interpRegs regs_i (
        .busClk(busClk), .arstN(arstN), .cs(cs),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .addr(addr), .dataIn(dataIn), .dataOut(dataOut),
        .bypass(bypass), .test(test), .invert(invert), .bypassEQ(bypassEQ),
        .source(source), .testValue(testValue),
        .exponent(exponent), .mantissa(mantissa)
    );

    interpSourceSel #(
        .NumSources(NumSources)
    ) sourceSel_i (
        .busClk(busClk), .arstN(arstN),
        .sourceData(sourceData), .sampleValid(sampleValid),
        .source(source), .test(test), .testValue(testValue),
        .selData(selData), .selValid(selValid)
    );

    interpGain gain_i (
        .busClk(busClk), .arstN(arstN),
        .selData(selData), .selValid(selValid),
        .mantissa(mantissa), .exponent(exponent), .invert(invert),
        .gainData(gainData), .gainValid(gainValid)
    );

    interpEqualizer equalizer_i (
        .busClk(busClk), .arstN(arstN),
        .gainData(gainData), .gainValid(gainValid), .bypassEQ(bypassEQ),
        .eqData(eqData), .eqValid(eqValid)
    );

    interpUpsampler upsampler_i (
        .busClk(busClk), .arstN(arstN),
        .eqData(eqData), .eqValid(eqValid), .bypass(bypass),
        .sampleOut(sampleOut), .outValid(outValid)
    );

endmodule

// ==== verilog/interpUpsampler.sv ====
// Upsampler by two with linear interpolation.
// Each valid input emits the midpoint to the previous sample, then the sample itself
// one cycle later. With bypass set only the sample is emitted.
// Inputs must be at least two cycles apart, otherwise a new midpoint replaces the
// pending second output.

`timescale 1ns/1ps

module interpUpsampler (
    input  logic                                     busClk,
    input  logic                                     arstN,
    input  logic signed [interpPkg::SampleWidth-1:0] eqData,
    input  logic                                     eqValid,
    input  logic                                     bypass,
    output logic signed [interpPkg::SampleWidth-1:0] sampleOut,
    output logic                                     outValid
);
    import interpPkg::*;

    typedef enum logic {
        Idle,
        SecondHalf  // The held sample still has to go out
    } UpState;

    UpState                        state;
    logic signed [SampleWidth-1:0] prevSample;
    logic signed [SampleWidth:0]   midSum;
    logic signed [SampleWidth-1:0] nextOut;
    logic                          emit;

    assign midSum = prevSample + eqData;
    assign emit   = eqValid || (state == SecondHalf);

    always_comb begin
        nextOut = prevSample;  // Second half of a pair
        if (eqValid) begin
            nextOut = bypass ? eqData : midSum[SampleWidth:1];
        end
    end

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            state      <= Idle;
            prevSample <= '0;
            outValid   <= 1'b0;
        end else begin
            outValid <= emit;
            if (eqValid) begin
                prevSample <= eqData;
                state      <= bypass ? Idle : SecondHalf;
            end else begin
                state <= Idle;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (emit) begin
            sampleOut <= nextOut;
        end
    end

endmodule
